// File: design/mem_unit_pkg.sv
package mem_unit_pkg;

    localparam int ADDR_W    = 32;
    localparam int WORD_W    = 32;
    localparam int BYTES     = WORD_W / 8;
    localparam int TAG_W     = 8;
    localparam int MEM_TAG_W = TAG_W + 1;
    localparam int PERF_W    = 32;

    // Source bit on top of the external tag
    localparam logic SRC_FETCH = 1'b0;
    localparam logic SRC_DATA  = 1'b1;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              rw;
        logic [BYTES-1:0]  byteen;
        logic [WORD_W-1:0] data;
        logic [TAG_W-1:0]  tag;
    } data_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [TAG_W-1:0]  tag;
    } fetch_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic [TAG_W-1:0]  tag;
    } core_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0]    addr;
        logic                 rw;
        logic [BYTES-1:0]     byteen;
        logic [WORD_W-1:0]    data;
        logic [MEM_TAG_W-1:0] tag;
    } mem_req_t;

    typedef struct packed {
        logic [WORD_W-1:0]    data;
        logic [MEM_TAG_W-1:0] tag;
    } mem_rsp_t;

    typedef struct packed {
        logic [PERF_W-1:0] reads;
        logic [PERF_W-1:0] writes;
        logic [PERF_W-1:0] latency;
    } perf_mem_t;

endpackage

// File: design/smem_router.sv
module smem_router import mem_unit_pkg::*; #(
    parameter logic [ADDR_W-1:0] SMEM_BASE  = 32'h0000_1000,
    parameter int                SMEM_WORDS = 64
) (
    input  logic      data_req_valid,
    input  data_req_t data_req,
    output logic      data_req_ready,

    output logic      smem_req_valid,
    output data_req_t smem_req,
    input  logic      smem_req_ready,

    output logic      ext_req_valid,
    output data_req_t ext_req,
    input  logic      ext_req_ready,

    input  logic      smem_rsp_valid,
    input  core_rsp_t smem_rsp,
    output logic      smem_rsp_ready,

    input  logic      ext_rsp_valid,
    input  core_rsp_t ext_rsp,
    output logic      ext_rsp_ready,

    output logic      data_rsp_valid,
    output core_rsp_t data_rsp,
    input  logic      data_rsp_ready
);

    // Lowest address bit above the window offset
    localparam int WIN_LSB = $clog2(BYTES) + $clog2(SMEM_WORDS);

    logic in_win;
    logic smem_free;

    assign in_win = (data_req.addr[ADDR_W-1:WIN_LSB] == SMEM_BASE[ADDR_W-1:WIN_LSB]);

    // An external response already on the output must not be overtaken
    assign smem_free = !(ext_rsp_valid && !smem_rsp_valid);

    assign smem_req_valid = data_req_valid && in_win && smem_free;
    assign ext_req_valid  = data_req_valid && !in_win;
    assign smem_req       = data_req;
    assign ext_req        = data_req;

    assign data_req_ready = in_win ? (smem_req_ready && smem_free) : ext_req_ready;

    // Scratchpad wins, it is the short path
    assign data_rsp_valid = smem_rsp_valid || ext_rsp_valid;
    assign data_rsp       = smem_rsp_valid ? smem_rsp : ext_rsp;
    assign smem_rsp_ready = data_rsp_ready;
    assign ext_rsp_ready  = data_rsp_ready && !smem_rsp_valid;

endmodule

// File: design/shared_mem.sv
module shared_mem import mem_unit_pkg::*; #(
    parameter int SMEM_WORDS = 64
) (
    input  logic      clk,
    input  logic      reset,

    input  logic      req_valid,
    input  data_req_t req,
    output logic      req_ready,

    output logic      rsp_valid,
    output core_rsp_t rsp,
    input  logic      rsp_ready
);

    localparam int IDX_W    = $clog2(SMEM_WORDS);
    localparam int WORD_LSB = $clog2(BYTES);

    logic [WORD_W-1:0] mem [SMEM_WORDS];

    logic [IDX_W-1:0]  idx;
    logic [WORD_W-1:0] rd_word;
    logic [WORD_W-1:0] wr_word;
    logic              req_fire;

    assign idx       = req.addr[WORD_LSB +: IDX_W];
    assign rd_word   = mem[idx];
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    // Byte merge of the write data into the stored word
    always_comb begin
        for (int b = 0; b < BYTES; b++) begin
            wr_word[b*8 +: 8] = req.byteen[b] ? req.data[b*8 +: 8] : rd_word[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            if (req.rw) begin
                mem[idx] <= wr_word;
            end
            rsp.data <= req.rw ? wr_word : rd_word;
            rsp.tag  <= req.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (req_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

endmodule

// File: design/mem_arb.sv
module mem_arb import mem_unit_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  logic       fetch_req_valid,
    input  fetch_req_t fetch_req,
    output logic       fetch_req_ready,

    input  logic       data_req_valid,
    input  data_req_t  data_req,
    output logic       data_req_ready,

    output logic       mem_req_valid,
    output mem_req_t   mem_req,
    input  logic       mem_req_ready,

    input  logic       mem_rsp_valid,
    input  mem_rsp_t   mem_rsp,
    output logic       mem_rsp_ready,

    output logic       fetch_rsp_valid,
    output core_rsp_t  fetch_rsp,
    input  logic       fetch_rsp_ready,

    output logic       data_rsp_valid,
    output core_rsp_t  data_rsp,
    input  logic       data_rsp_ready
);

    logic prio;
    logic locked;
    logic lock_src;
    logic grant;
    logic rsp_src;

    always_comb begin
        if (locked) begin
            grant = lock_src;
        end else if (fetch_req_valid && data_req_valid) begin
            grant = prio;
        end else begin
            grant = data_req_valid ? SRC_DATA : SRC_FETCH;
        end
    end

    assign mem_req_valid   = fetch_req_valid || data_req_valid;
    assign fetch_req_ready = mem_req_ready && (grant == SRC_FETCH);
    assign data_req_ready  = mem_req_ready && (grant == SRC_DATA);

    always_comb begin
        if (grant == SRC_DATA) begin
            mem_req.addr   = data_req.addr;
            mem_req.rw     = data_req.rw;
            mem_req.byteen = data_req.byteen;
            mem_req.data   = data_req.data;
            mem_req.tag    = {SRC_DATA, data_req.tag};
        end else begin
            // Fetches are plain reads
            mem_req.addr   = fetch_req.addr;
            mem_req.rw     = 1'b0;
            mem_req.byteen = '0;
            mem_req.data   = '0;
            mem_req.tag    = {SRC_FETCH, fetch_req.tag};
        end
    end

    // Other source first after a transfer, held grant while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            prio     <= SRC_FETCH;
            locked   <= 1'b0;
            lock_src <= SRC_FETCH;
        end else if (mem_req_valid && mem_req_ready) begin
            prio   <= ~grant;
            locked <= 1'b0;
        end else if (mem_req_valid) begin
            locked   <= 1'b1;
            lock_src <= grant;
        end
    end

    assign rsp_src = mem_rsp.tag[MEM_TAG_W-1];

    assign fetch_rsp_valid = mem_rsp_valid && (rsp_src == SRC_FETCH);
    assign data_rsp_valid  = mem_rsp_valid && (rsp_src == SRC_DATA);
    assign fetch_rsp.data  = mem_rsp.data;
    assign fetch_rsp.tag   = mem_rsp.tag[TAG_W-1:0];
    assign data_rsp.data   = mem_rsp.data;
    assign data_rsp.tag    = mem_rsp.tag[TAG_W-1:0];
    assign mem_rsp_ready   = (rsp_src == SRC_DATA) ? data_rsp_ready : fetch_rsp_ready;

endmodule

// File: design/mem_perf.sv
module mem_perf import mem_unit_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      mem_req_valid,
    input  logic      mem_req_ready,
    input  logic      mem_req_rw,
    input  logic      mem_rsp_valid,
    input  logic      mem_rsp_ready,
    output perf_mem_t perf
);

    logic              rd_fire;
    logic              wr_fire;
    logic              rsp_fire;
    logic [PERF_W-1:0] pending;

    assign rd_fire  = mem_req_valid && mem_req_ready && !mem_req_rw;
    assign wr_fire  = mem_req_valid && mem_req_ready && mem_req_rw;
    assign rsp_fire = mem_rsp_valid && mem_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending      <= '0;
            perf.reads   <= '0;
            perf.writes  <= '0;
            perf.latency <= '0;
        end else begin
            // Reads in flight
            pending <= pending + PERF_W'(rd_fire) - PERF_W'(rsp_fire);
            if (rd_fire) begin
                perf.reads <= perf.reads + 1'b1;
            end
            if (wr_fire) begin
                perf.writes <= perf.writes + 1'b1;
            end
            perf.latency <= perf.latency + pending;
        end
    end

endmodule

// File: design/mem_unit.sv
module mem_unit import mem_unit_pkg::*; #(
    parameter logic [ADDR_W-1:0] SMEM_BASE  = 32'h0000_1000,
    parameter int                SMEM_WORDS = 64
) (
    input  logic       clk,
    input  logic       reset,

    input  logic       fetch_req_valid,
    input  fetch_req_t fetch_req,
    output logic       fetch_req_ready,
    output logic       fetch_rsp_valid,
    output core_rsp_t  fetch_rsp,
    input  logic       fetch_rsp_ready,

    input  logic       data_req_valid,
    input  data_req_t  data_req,
    output logic       data_req_ready,
    output logic       data_rsp_valid,
    output core_rsp_t  data_rsp,
    input  logic       data_rsp_ready,

    output logic       mem_req_valid,
    output mem_req_t   mem_req,
    input  logic       mem_req_ready,
    input  logic       mem_rsp_valid,
    input  mem_rsp_t   mem_rsp,
    output logic       mem_rsp_ready,

    output perf_mem_t  perf
);

    logic      smem_req_valid;
    data_req_t smem_req;
    logic      smem_req_ready;
    logic      smem_rsp_valid;
    core_rsp_t smem_rsp;
    logic      smem_rsp_ready;

    logic      ext_data_req_valid;
    data_req_t ext_data_req;
    logic      ext_data_req_ready;
    logic      ext_data_rsp_valid;
    core_rsp_t ext_data_rsp;
    logic      ext_data_rsp_ready;

    smem_router #(
        .SMEM_BASE  (SMEM_BASE),
        .SMEM_WORDS (SMEM_WORDS)
    ) i_smem_router (
        .data_req_valid (data_req_valid),
        .data_req       (data_req),
        .data_req_ready (data_req_ready),
        .smem_req_valid (smem_req_valid),
        .smem_req       (smem_req),
        .smem_req_ready (smem_req_ready),
        .ext_req_valid  (ext_data_req_valid),
        .ext_req        (ext_data_req),
        .ext_req_ready  (ext_data_req_ready),
        .smem_rsp_valid (smem_rsp_valid),
        .smem_rsp       (smem_rsp),
        .smem_rsp_ready (smem_rsp_ready),
        .ext_rsp_valid  (ext_data_rsp_valid),
        .ext_rsp        (ext_data_rsp),
        .ext_rsp_ready  (ext_data_rsp_ready),
        .data_rsp_valid (data_rsp_valid),
        .data_rsp       (data_rsp),
        .data_rsp_ready (data_rsp_ready)
    );

    shared_mem #(
        .SMEM_WORDS (SMEM_WORDS)
    ) i_shared_mem (
        .clk       (clk),
        .reset     (reset),
        .req_valid (smem_req_valid),
        .req       (smem_req),
        .req_ready (smem_req_ready),
        .rsp_valid (smem_rsp_valid),
        .rsp       (smem_rsp),
        .rsp_ready (smem_rsp_ready)
    );

    mem_arb i_mem_arb (
        .clk             (clk),
        .reset           (reset),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_req_ready (fetch_req_ready),
        .data_req_valid  (ext_data_req_valid),
        .data_req        (ext_data_req),
        .data_req_ready  (ext_data_req_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp         (mem_rsp),
        .mem_rsp_ready   (mem_rsp_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_ready (fetch_rsp_ready),
        .data_rsp_valid  (ext_data_rsp_valid),
        .data_rsp        (ext_data_rsp),
        .data_rsp_ready  (ext_data_rsp_ready)
    );

    mem_perf i_mem_perf (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_rw    (mem_req.rw),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .perf          (perf)
    );

endmodule

// File: tests/ext_mem_model.sv
module ext_mem_model import mem_unit_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     mem_req_valid,
    input  mem_req_t mem_req,
    output logic     mem_req_ready,
    output logic     mem_rsp_valid,
    output mem_rsp_t mem_rsp,
    input  logic     mem_rsp_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [WORD_W-1:0] words [logic [ADDR_W-1:0]];
    mem_rsp_t          queued_rsp [$];
    int                queued_dly [$];
    logic              rsp_taken;

    // Unwritten words read back as the inverted address
    function automatic logic [WORD_W-1:0] word_at(logic [ADDR_W-1:0] addr);
        return words.exists(addr) ? words[addr] : ~addr;
    endfunction

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        rsp_taken     = 1'b0;
    end

    always @(posedge clk) begin : accept
        logic [WORD_W-1:0] w;
        rsp_taken <= mem_rsp_valid && mem_rsp_ready;
        if (!reset && mem_req_valid && mem_req_ready) begin
            w = word_at(mem_req.addr);
            if (mem_req.rw) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (mem_req.byteen[b]) begin
                        w[b*8 +: 8] = mem_req.data[b*8 +: 8];
                    end
                end
                words[mem_req.addr] = w;
            end
            queued_rsp.push_back('{data: w, tag: mem_req.tag});
            queued_dly.push_back(1 + int'($urandom % 6));
        end
    end

    always @(negedge clk) begin : answer
        int ready_idx [$];
        int k;
        if (reset) begin
            mem_req_ready = 1'b0;
            mem_rsp_valid = 1'b0;
        end else begin
            mem_req_ready = ($urandom % 3) != 0;
            if (rsp_taken) begin
                mem_rsp_valid = 1'b0;
            end
            foreach (queued_dly[i]) begin
                if (queued_dly[i] > 0) begin
                    queued_dly[i]--;
                end
            end
            // Any finished entry may go next, so order is not kept
            if (!mem_rsp_valid) begin
                ready_idx.delete();
                foreach (queued_dly[i]) begin
                    if (queued_dly[i] == 0) begin
                        ready_idx.push_back(i);
                    end
                end
                if (ready_idx.size() > 0) begin
                    k = ready_idx[$urandom % ready_idx.size()];
                    mem_rsp       = queued_rsp[k];
                    mem_rsp_valid = 1'b1;
                    queued_rsp.delete(k);
                    queued_dly.delete(k);
                end
            end
        end
    end

endmodule

// File: tests/tb_mem_unit.sv
module tb_mem_unit import mem_unit_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [ADDR_W-1:0] SMEM_BASE  = 32'h0000_1000;
    localparam int                SMEM_WORDS = 64;
    localparam int                N_FETCH    = 48;
    localparam int                N_DATA     = 48;
    localparam int                WIN_LSB    = $clog2(BYTES) + $clog2(SMEM_WORDS);

    logic clk;
    logic reset;
    logic fetch_req_valid, fetch_req_ready, fetch_rsp_valid, fetch_rsp_ready;
    logic data_req_valid, data_req_ready, data_rsp_valid, data_rsp_ready;
    logic mem_req_valid, mem_req_ready, mem_rsp_valid, mem_rsp_ready;
    fetch_req_t fetch_req;
    data_req_t  data_req;
    core_rsp_t  fetch_rsp, data_rsp;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;
    perf_mem_t  perf;

    int errors;
    int data_done;
    int fetch_done;
    logic data_fire, data_rsp_fire, fetch_fire;
    logic [WORD_W-1:0] exp_data [256];
    logic [ADDR_W-1:0] fetch_addr [256];
    bit data_pend [256];
    bit fetch_pend [256];
    logic [WORD_W-1:0] smem_words [SMEM_WORDS];
    logic [WORD_W-1:0] ext_words [logic [ADDR_W-1:0]];
    logic [PERF_W-1:0] rd_cnt, wr_cnt, pend_cnt, lat_sum;
    logic both_run;
    logic last_src;
    logic ext_data_valid;
    logic mem_fire;

    mem_unit #(.SMEM_BASE(SMEM_BASE), .SMEM_WORDS(SMEM_WORDS)) i_mem_unit (.*);
    ext_mem_model i_ext_mem_model (.*);

    function automatic logic in_smem(logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1:WIN_LSB] == SMEM_BASE[ADDR_W-1:WIN_LSB];
    endfunction

    function automatic logic [WORD_W-1:0] merge_bytes(logic [WORD_W-1:0] old,
            logic [WORD_W-1:0] wdata, logic [BYTES-1:0] be);
        for (int b = 0; b < BYTES; b++) begin
            if (be[b]) begin
                old[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return old;
    endfunction

    task automatic report_fail(string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    assign ext_data_valid = data_req_valid && !in_smem(data_req.addr);
    assign mem_fire       = mem_req_valid && mem_req_ready;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(negedge clk) begin
        data_rsp_ready  = reset || (($urandom % 3) != 0);
        fetch_rsp_ready = reset || (($urandom % 4) != 0);
    end

    // Handshakes seen at the edge and reference perf counts
    always @(posedge clk) begin
        data_fire     <= data_req_valid && data_req_ready;
        data_rsp_fire <= data_rsp_valid && data_rsp_ready;
        fetch_fire    <= fetch_req_valid && fetch_req_ready;
        if (data_req_valid && data_req_ready) data_pend[data_req.tag] <= 1'b1;
        if (data_rsp_valid && data_rsp_ready) data_pend[data_rsp.tag] <= 1'b0;
        if (fetch_req_valid && fetch_req_ready) fetch_pend[fetch_req.tag] <= 1'b1;
        if (fetch_rsp_valid && fetch_rsp_ready) fetch_pend[fetch_rsp.tag] <= 1'b0;
        if (reset) begin
            rd_cnt   <= '0;
            wr_cnt   <= '0;
            pend_cnt <= '0;
            lat_sum  <= '0;
            both_run <= 1'b0;
            last_src <= SRC_FETCH;
        end else begin
            rd_cnt   <= rd_cnt + PERF_W'(mem_fire && !mem_req.rw);
            wr_cnt   <= wr_cnt + PERF_W'(mem_fire && mem_req.rw);
            pend_cnt <= pend_cnt + PERF_W'(mem_fire && !mem_req.rw)
                        - PERF_W'(mem_rsp_valid && mem_rsp_ready);
            lat_sum  <= lat_sum + pend_cnt;
            if (mem_fire) begin
                last_src <= mem_req.tag[MEM_TAG_W-1];
                both_run <= 1'b1;
            end else begin
                both_run <= both_run && fetch_req_valid && ext_data_valid;
            end
        end
    end

    a_smem_latency: assert property (@(posedge clk) disable iff (reset)
        (data_req_valid && data_req_ready && in_smem(data_req.addr)) |=>
        (data_rsp_valid && data_rsp.tag == $past(data_req.tag)))
        else report_fail("scratchpad response not one cycle after acceptance");
    a_no_ext_smem: assert property (@(posedge clk) disable iff (reset)
        mem_fire |-> !in_smem(mem_req.addr))
        else report_fail("scratchpad access reached mem_req");
    a_data_out: assert property (@(posedge clk) disable iff (reset)
        (mem_req_valid && mem_req.tag[MEM_TAG_W-1] == SRC_DATA) |->
        (mem_req.tag[TAG_W-1:0] == data_req.tag && mem_req.addr == data_req.addr))
        else report_fail("data request on mem_req has wrong tag or address");
    a_fetch_out: assert property (@(posedge clk) disable iff (reset)
        (mem_req_valid && mem_req.tag[MEM_TAG_W-1] == SRC_FETCH) |->
        (!mem_req.rw && mem_req.tag[TAG_W-1:0] == fetch_req.tag
         && mem_req.addr == fetch_req.addr))
        else report_fail("fetch on mem_req is not a read with its tag");
    a_data_rsp: assert property (@(posedge clk) disable iff (reset)
        (data_rsp_valid && data_rsp_ready) |->
        (data_pend[data_rsp.tag] && data_rsp.data == exp_data[data_rsp.tag]))
        else report_fail("data response unexpected or wrong data");
    a_fetch_rsp: assert property (@(posedge clk) disable iff (reset)
        (fetch_rsp_valid && fetch_rsp_ready) |->
        (fetch_pend[fetch_rsp.tag] && fetch_rsp.data == ~fetch_addr[fetch_rsp.tag]))
        else report_fail("fetch response unexpected or wrong data");
    a_fetch_route: assert property (@(posedge clk) disable iff (reset)
        (mem_rsp_valid && mem_rsp.tag[MEM_TAG_W-1] == SRC_FETCH) |-> fetch_rsp_valid)
        else report_fail("fetch response not on fetch_rsp");
    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        (data_rsp_valid && !data_rsp_ready) |=> (data_rsp_valid && $stable(data_rsp)))
        else report_fail("stalled data response changed");
    a_alternate: assert property (@(posedge clk) disable iff (reset)
        (mem_fire && both_run && fetch_req_valid && ext_data_valid) |->
        (mem_req.tag[MEM_TAG_W-1] != last_src))
        else report_fail("arbiter did not alternate");
    a_perf: assert property (@(posedge clk) disable iff (reset)
        perf.reads == rd_cnt && perf.writes == wr_cnt && perf.latency == lat_sum)
        else report_fail("perf counters differ from reference");

    task automatic issue_data(logic [ADDR_W-1:0] addr, logic rw, logic [BYTES-1:0] be,
            logic [WORD_W-1:0] wdata, int tag);
        logic [WORD_W-1:0] old;
        logic [WORD_W-1:0] w;
        if (in_smem(addr)) begin
            old = smem_words[addr[WIN_LSB-1:2]];
        end else begin
            old = ext_words.exists(addr) ? ext_words[addr] : ~addr;
        end
        w = rw ? merge_bytes(old, wdata, be) : old;
        exp_data[tag] = w;
        if (rw && in_smem(addr)) smem_words[addr[WIN_LSB-1:2]] = w;
        if (rw && !in_smem(addr)) ext_words[addr] = w;
        @(negedge clk);
        data_req_valid = 1'b1;
        data_req = '{addr: addr, rw: rw, byteen: be, data: wdata, tag: TAG_W'(tag)};
        do @(negedge clk); while (!data_fire);
        data_req_valid = 1'b0;
        do @(negedge clk); while (!data_rsp_fire);
        data_done++;
    endtask

    initial begin : watchdog
        #(200 * (N_FETCH + N_DATA) * 4);
        $display("Timeout: run did not finish, %0d errors so far", errors);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main
        logic [ADDR_W-1:0] a;
        void'($urandom(32'haa54));
        errors = 0;
        data_done = 0;
        fetch_done = 0;
        reset = 1'b1;
        fetch_req_valid = 1'b0;
        fetch_req = '0;
        data_req_valid = 1'b0;
        data_req = '0;
        data_rsp_ready = 1'b1;
        fetch_rsp_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        fork
            begin
                // Back to back fetches keep the arbiter contended
                for (int i = 0; i < N_FETCH; i++) begin
                    fetch_addr[i] = 32'h8000_0000 + 32'(i * 4);
                    fetch_req_valid = 1'b1;
                    fetch_req = '{addr: fetch_addr[i], tag: TAG_W'(i)};
                    do @(negedge clk); while (!fetch_fire);
                    fetch_done++;
                end
                fetch_req_valid = 1'b0;
            end
            begin
                for (int i = 0; i < N_DATA - 24; i++) begin
                    a = 32'h2000 + 32'(($urandom % 8) * 4);
                    issue_data(a, 1'($urandom), BYTES'($urandom), $urandom, i);
                end
                for (int i = 0; i < 8; i++) begin
                    a = SMEM_BASE + 32'(i * 8);
                    issue_data(a, 1'b1, 4'hf, $urandom, N_DATA - 24 + 3 * i);
                    issue_data(a, 1'b1, BYTES'($urandom), $urandom, N_DATA - 23 + 3 * i);
                    issue_data(a, 1'b0, '0, '0, N_DATA - 22 + 3 * i);
                end
            end
        join
        repeat (40) @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            if (data_pend[i] || fetch_pend[i]) begin
                errors++;
                $display("Request with tag %0d never got its response", i);
            end
        end
        $display("Done: %0d data, %0d fetch requests, %0d errors",
                 data_done, fetch_done, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: files.f
design/mem_unit_pkg.sv
design/smem_router.sv
design/shared_mem.sv
design/mem_arb.sv
design/mem_perf.sv
design/mem_unit.sv
tests/ext_mem_model.sv
tests/tb_mem_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_unit
RTL_TOP   ?= mem_unit
FLIST     ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
